// File: Makefile
VERILATOR ?= verilator
TOP       ?= play_render_tb
FILELIST  ?= play_render.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "All tests passed" $(LOG) || (echo "simulation reported failure"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hdl/card_board.sv
`timescale 1ns/10ps

module card_board (
    input  logic                  clk_25MHz,
    input  logic                  rst_n,
    input  render_pkg::coord_t    h_cnt,
    input  render_pkg::coord_t    v_cnt,
    input  render_pkg::cooldown_t cooldowns [render_pkg::NUM_CARDS],
    output logic                  card_hit,
    output render_pkg::rgb_t      card_colour
);
    import render_pkg::*;

    localparam int IDX_W = $clog2(NUM_CARDS);

    logic             in_row;
    logic             card_found;
    logic [IDX_W-1:0] card_idx;
    coord_t           col_ofs;
    coord_t           row_ofs;
    logic             on_border;

    logic             found_d1;
    logic             border_d1;
    coord_t           col_d1;
    cooldown_t        cd_d1;
    logic             shade;

    function automatic coord_t card_left(input int idx);
        return CARD_LEFT0 + coord_t'(idx) * CARD_PITCH;
    endfunction

    assign in_row  = (v_cnt >= CARD_TOP) && (v_cnt < CARD_TOP + CARD_H);
    assign row_ofs = v_cnt - CARD_TOP;

    // cards never overlap, so at most one matches
    always_comb begin
        card_found = 1'b0;
        card_idx   = '0;
        col_ofs    = '0;
        for (int i = 0; i < NUM_CARDS; i++) begin
            if (in_row && h_cnt >= card_left(i) && h_cnt < card_left(i) + CARD_W) begin
                card_found = 1'b1;
                card_idx   = IDX_W'(i);
                col_ofs    = h_cnt - card_left(i);
            end
        end
    end

    assign on_border = (col_ofs < CARD_BORDER) || (col_ofs >= CARD_W - CARD_BORDER)
                    || (row_ofs < CARD_BORDER) || (row_ofs >= CARD_H - CARD_BORDER);

    always_ff @(posedge clk_25MHz) begin
        if (!rst_n) begin
            found_d1 <= 1'b0;
            card_hit <= 1'b0;
        end else begin
            found_d1 <= card_found;
            card_hit <= found_d1;
        end
    end

    // shade grows from the right edge as cooldown falls
    assign shade = (cd_d1 != '0) && (col_d1 > coord_t'(cd_d1) * CD_STEP);

    always_ff @(posedge clk_25MHz) begin
        border_d1 <= on_border;
        col_d1    <= col_ofs;
        cd_d1     <= cooldowns[card_idx];
        if (border_d1) begin
            card_colour <= COL_BLACK;
        end else if (shade) begin
            card_colour <= COL_GREY;
        end else begin
            card_colour <= COL_WHITE;
        end
    end

endmodule

// File: hdl/play_render.sv
`timescale 1ns/10ps

module play_render (
    input  logic                  clk_25MHz,
    input  logic                  rst_n,
    input  render_pkg::coord_t    h_cnt,
    input  render_pkg::coord_t    v_cnt,
    input  render_pkg::unit_t     units [render_pkg::NUM_UNITS],
    input  render_pkg::cooldown_t cooldowns [render_pkg::NUM_CARDS],
    output render_pkg::rgb_t      pixel
);
    import render_pkg::*;

    unit_hit_t unit_hits [NUM_UNITS];
    logic      card_hit;
    rgb_t      card_colour;

    coord_t    h_d1;
    coord_t    h_d2;
    coord_t    v_d1;
    coord_t    v_d2;

    genvar gi;
    generate
        for (gi = 0; gi < NUM_UNITS; gi++) begin : g_unit
            unit_pixel_pipe u_unit_pipe (
                .clk_25MHz (clk_25MHz),
                .rst_n     (rst_n),
                .h_cnt     (h_cnt),
                .v_cnt     (v_cnt),
                .unit      (units[gi]),
                .hit       (unit_hits[gi])
            );
        end
    endgenerate

    card_board u_card_board (
        .clk_25MHz   (clk_25MHz),
        .rst_n       (rst_n),
        .h_cnt       (h_cnt),
        .v_cnt       (v_cnt),
        .cooldowns   (cooldowns),
        .card_hit    (card_hit),
        .card_colour (card_colour)
    );

    // coordinate follows the unit and card pipes by two stages
    // off-screen reset value keeps pixel black while the pipe refills
    always_ff @(posedge clk_25MHz) begin
        if (!rst_n) begin
            h_d1 <= SCREEN_W;
            h_d2 <= SCREEN_W;
            v_d1 <= SCREEN_H;
            v_d2 <= SCREEN_H;
        end else begin
            h_d1 <= h_cnt;
            h_d2 <= h_d1;
            v_d1 <= v_cnt;
            v_d2 <= v_d1;
        end
    end

    scene_compose u_scene_compose (
        .clk_25MHz   (clk_25MHz),
        .rst_n       (rst_n),
        .h_cnt       (h_d2),
        .v_cnt       (v_d2),
        .unit_hits   (unit_hits),
        .card_hit    (card_hit),
        .card_colour (card_colour),
        .pixel       (pixel)
    );

endmodule

// File: hdl/render_pkg.sv
package render_pkg;

    // unit and card slot counts
    localparam int NUM_UNITS = 4;
    localparam int NUM_CARDS = 4;
    localparam int NUM_KINDS = 4;

    typedef logic [9:0]  coord_t;
    typedef logic [11:0] rgb_t;
    typedef logic [4:0]  cooldown_t;

    // visible area and playfield split
    localparam coord_t SCREEN_W         = 10'd640;
    localparam coord_t SCREEN_H         = 10'd480;
    localparam coord_t PLAYFIELD_BOTTOM = 10'd270;

    // background bands
    localparam coord_t SKY_END     = 10'd140;
    localparam coord_t PATH_TOP    = 10'd170;
    localparam coord_t PATH_BOTTOM = 10'd230;

    // card row on the lower board
    localparam coord_t CARD_LEFT0  = 10'd105;
    localparam coord_t CARD_PITCH  = 10'd110;
    localparam coord_t CARD_TOP    = 10'd290;
    localparam coord_t CARD_W      = 10'd100;
    localparam coord_t CARD_H      = 10'd80;
    localparam coord_t CARD_BORDER = 10'd2;
    localparam coord_t CD_STEP     = 10'd3;

    localparam int SPRITE_SCALE_SHIFT = 1;
    localparam int RENDER_LATENCY     = 3;

    localparam rgb_t COL_SKY   = 12'h2BF;
    localparam rgb_t COL_GRASS = 12'h5B2;
    localparam rgb_t COL_PATH  = 12'hDA5;
    localparam rgb_t COL_BOARD = 12'hFB7;
    localparam rgb_t COL_WHITE = 12'hFFF;
    localparam rgb_t COL_RED   = 12'hF00;
    localparam rgb_t COL_BLACK = 12'h000;
    localparam rgb_t COL_GREY  = 12'h666;

    typedef enum logic [1:0] {
        KIND_KNIGHT = 2'd0,
        KIND_ARCHER = 2'd1,
        KIND_SLIME  = 2'd2,
        KIND_BAT    = 2'd3
    } unit_kind_e;

    // code 3 is see-through
    typedef enum logic [1:0] {
        CODE_WHITE = 2'd0,
        CODE_BLACK = 2'd1,
        CODE_RED   = 2'd2,
        CODE_CLEAR = 2'd3
    } sprite_code_e;

    // x and y are the top-left corner on screen
    typedef struct packed {
        logic       exist;
        unit_kind_e kind;
        coord_t     x;
        coord_t     y;
    } unit_t;

    typedef struct packed {
        logic         hit;
        sprite_code_e code;
    } unit_hit_t;

    // sprite size in sprite pixels, indexed by kind
    localparam logic [4:0] SPRITE_W [NUM_KINDS] = '{5'd16, 5'd12, 5'd10, 5'd14};
    localparam logic [4:0] SPRITE_H [NUM_KINDS] = '{5'd12, 5'd16, 5'd8, 5'd10};

endpackage

// File: hdl/scene_compose.sv
`timescale 1ns/10ps

module scene_compose (
    input  logic                  clk_25MHz,
    input  logic                  rst_n,
    input  render_pkg::coord_t    h_cnt,
    input  render_pkg::coord_t    v_cnt,
    input  render_pkg::unit_hit_t unit_hits [render_pkg::NUM_UNITS],
    input  logic                  card_hit,
    input  render_pkg::rgb_t      card_colour,
    output render_pkg::rgb_t      pixel
);
    import render_pkg::*;

    logic         unit_found;
    sprite_code_e unit_code;
    rgb_t         unit_colour;
    rgb_t         band_colour;
    rgb_t         next_pixel;

    // first hit wins, so lower index is on top
    always_comb begin
        unit_found = 1'b0;
        unit_code  = CODE_CLEAR;
        for (int i = 0; i < NUM_UNITS; i++) begin
            if (!unit_found && unit_hits[i].hit) begin
                unit_found = 1'b1;
                unit_code  = unit_hits[i].code;
            end
        end
    end

    always_comb begin
        case (unit_code)
            CODE_WHITE: unit_colour = COL_WHITE;
            CODE_RED:   unit_colour = COL_RED;
            default:    unit_colour = COL_BLACK;
        endcase
    end

    // fixed scenery behind the units
    always_comb begin
        if (v_cnt >= PATH_TOP && v_cnt < PATH_BOTTOM) begin
            band_colour = COL_PATH;
        end else if (v_cnt >= SKY_END) begin
            band_colour = COL_GRASS;
        end else begin
            band_colour = COL_SKY;
        end
    end

    always_comb begin
        if (h_cnt >= SCREEN_W || v_cnt >= SCREEN_H) begin
            next_pixel = COL_BLACK;
        end else if (v_cnt < PLAYFIELD_BOTTOM) begin
            next_pixel = unit_found ? unit_colour : band_colour;
        end else begin
            next_pixel = card_hit ? card_colour : COL_BOARD;
        end
    end

    always_ff @(posedge clk_25MHz) begin
        if (!rst_n) begin
            pixel <= COL_BLACK;
        end else begin
            pixel <= next_pixel;
        end
    end

endmodule

// File: hdl/sprite_rom.sv
`timescale 1ns/10ps

module sprite_rom (
    input  logic                     clk_25MHz,
    input  render_pkg::unit_kind_e   kind,
    input  logic [3:0]               lx,
    input  logic [3:0]               ly,
    output render_pkg::sprite_code_e code
);
    import render_pkg::*;

    // 4x4 blocks of sprite pixels share one code
    logic [1:0] block_x;
    logic [1:0] block_y;
    logic [1:0] code_sum;

    assign block_x = lx[3:2];
    assign block_y = ly[3:2];

    // kind shifts the pattern so each unit looks different
    // 2-bit sum wraps modulo 4
    assign code_sum = block_x + block_y + kind;

    // one lookup per cycle, registered like a block ram read
    always_ff @(posedge clk_25MHz) begin
        code <= sprite_code_e'(code_sum);
    end

endmodule

// File: hdl/unit_pixel_pipe.sv
`timescale 1ns/10ps

module unit_pixel_pipe (
    input  logic                  clk_25MHz,
    input  logic                  rst_n,
    input  render_pkg::coord_t    h_cnt,
    input  render_pkg::coord_t    v_cnt,
    input  render_pkg::unit_t     unit,
    output render_pkg::unit_hit_t hit
);
    import render_pkg::*;

    // end of the scaled box, one bit wider so x + 2w cannot wrap
    logic [10:0] x_end;
    logic [10:0] y_end;
    coord_t      dx;
    coord_t      dy;
    logic        in_box;

    // stage 1
    logic        in_box_d1;
    unit_kind_e  kind_d1;
    logic [3:0]  lx_d1;
    logic [3:0]  ly_d1;

    // stage 2
    logic         in_box_d2;
    sprite_code_e code;

    assign x_end = {1'b0, unit.x} + (11'(SPRITE_W[unit.kind]) << SPRITE_SCALE_SHIFT);
    assign y_end = {1'b0, unit.y} + (11'(SPRITE_H[unit.kind]) << SPRITE_SCALE_SHIFT);

    assign dx = h_cnt - unit.x;
    assign dy = v_cnt - unit.y;

    // right and bottom edges are exclusive
    assign in_box = unit.exist
                 && (h_cnt >= unit.x) && ({1'b0, h_cnt} < x_end)
                 && (v_cnt >= unit.y) && ({1'b0, v_cnt} < y_end);

    always_ff @(posedge clk_25MHz) begin
        if (!rst_n) begin
            in_box_d1 <= 1'b0;
            in_box_d2 <= 1'b0;
        end else begin
            in_box_d1 <= in_box;
            in_box_d2 <= in_box_d1;
        end
    end

    // sprite address, only meaningful when in_box
    always_ff @(posedge clk_25MHz) begin
        kind_d1 <= unit.kind;
        lx_d1   <= dx[SPRITE_SCALE_SHIFT +: 4];
        ly_d1   <= dy[SPRITE_SCALE_SHIFT +: 4];
    end

    sprite_rom u_sprite_rom (
        .clk_25MHz (clk_25MHz),
        .kind      (kind_d1),
        .lx        (lx_d1),
        .ly        (ly_d1),
        .code      (code)
    );

    // clear code lets the next source show through
    assign hit.hit  = in_box_d2 && (code != CODE_CLEAR);
    assign hit.code = code;

endmodule

// File: play_render.f
hdl/render_pkg.sv
hdl/sprite_rom.sv
hdl/unit_pixel_pipe.sv
hdl/card_board.sv
hdl/scene_compose.sv
hdl/play_render.sv
verification/play_render_properties.sv
verification/play_render_tb.sv

// File: verification/play_render_properties.sv
`timescale 1ns/10ps

module play_render_properties (
    input logic                  clk_25MHz,
    input logic                  rst_n,
    input render_pkg::unit_hit_t unit_hits [render_pkg::NUM_UNITS],
    input render_pkg::rgb_t      pixel
);
    import render_pkg::*;

    int   reset_errors = 0;
    int   refill_errors = 0;
    int   clear_errors = 0;
    int   assert_failures;
    logic clear_hit;

    assign assert_failures = reset_errors + refill_errors + clear_errors;

    // any unit flagging a hit with the see-through code
    always_comb begin
        clear_hit = 1'b0;
        for (int i = 0; i < NUM_UNITS; i++) begin
            if (unit_hits[i].hit && unit_hits[i].code == CODE_CLEAR) begin
                clear_hit = 1'b1;
            end
        end
    end

    reset_black: assert property (@(posedge clk_25MHz) !rst_n |=> pixel == COL_BLACK)
        else begin
            reset_errors++;
            $error("pixel not black while reset is low");
        end

    // pipe still holds reset values for three edges
    refill_black: assert property (@(posedge clk_25MHz)
        $rose(rst_n) |-> (pixel == COL_BLACK) [*RENDER_LATENCY])
        else begin
            refill_errors++;
            $error("pixel left black too early after reset");
        end

    no_clear_hit: assert property (@(posedge clk_25MHz) disable iff (!rst_n) !clear_hit)
        else begin
            clear_errors++;
            $error("unit hit flagged with the clear sprite code");
        end

endmodule

bind play_render play_render_properties u_play_render_properties (
    .clk_25MHz (clk_25MHz),
    .rst_n     (rst_n),
    .unit_hits (unit_hits),
    .pixel     (pixel)
);

// File: verification/play_render_tb.sv
`timescale 1ns/10ps

module play_render_tb;
    import render_pkg::*;

    localparam int NUM_ROWS   = 7;
    localparam int NUM_FIXED  = 5;
    localparam int NUM_POINTS = 8;
    localparam int MAX_CYCLES = 1000;
    localparam int SPRITE_COLS [4] = '{16, 12, 10, 14};
    localparam int SPRITE_ROWS [4] = '{12, 16, 8, 10};

    typedef struct packed {
        unit_t     [NUM_UNITS-1:0]  units;
        cooldown_t [NUM_CARDS-1:0]  cds;
        coord_t    [NUM_POINTS-1:0] hs;
        coord_t    [NUM_POINTS-1:0] vs;
        rgb_t      [NUM_POINTS-1:0] expected;
    } test_row_t;

    logic      clk_25MHz;
    logic      rst_n;
    coord_t    h_cnt;
    coord_t    v_cnt;
    unit_t     units [NUM_UNITS];
    cooldown_t cooldowns [NUM_CARDS];
    rgb_t      pixel;

    test_row_t rows [NUM_ROWS];
    string     row_names [NUM_ROWS] = '{"bands", "sprite codes", "priority", "card frames",
                                        "cooldown shade", "random a", "random b"};
    int        points [NUM_FIXED][NUM_POINTS][2];
    int        error_count = 0;
    int        test_errors;
    int        tests_failed = 0;
    int        seed = 32'h86628b2c;

    play_render u_play_render (
        .clk_25MHz (clk_25MHz),
        .rst_n     (rst_n),
        .h_cnt     (h_cnt),
        .v_cnt     (v_cnt),
        .units     (units),
        .cooldowns (cooldowns),
        .pixel     (pixel)
    );

    initial clk_25MHz = 1'b0;
    always #20 clk_25MHz = ~clk_25MHz;

    function automatic unit_t make_unit(input logic exist, input unit_kind_e kind,
                                        input int x, input int y);
        unit_t u;
        u.exist = exist;
        u.kind  = kind;
        u.x     = coord_t'(x);
        u.y     = coord_t'(y);
        return u;
    endfunction

    // reference pixel straight from the screen rules
    function automatic rgb_t model_pixel(input test_row_t row, input int h, input int v);
        unit_t u;
        int    ux;
        int    uy;
        int    code;
        int    left;
        int    ofs;
        int    cd;
        if (h >= 640 || v >= 480) return COL_BLACK;
        if (v < 270) begin
            for (int i = 0; i < NUM_UNITS; i++) begin
                u  = row.units[i];
                ux = int'(u.x);
                uy = int'(u.y);
                if (u.exist && h >= ux && h < ux + 2 * SPRITE_COLS[u.kind]
                    && v >= uy && v < uy + 2 * SPRITE_ROWS[u.kind]) begin
                    code = ((h - ux) / 8 + (v - uy) / 8 + int'(u.kind)) % 4;
                    if (code == 0) return COL_WHITE;
                    if (code == 1) return COL_BLACK;
                    if (code == 2) return COL_RED;
                end
            end
            if (v < 140) return COL_SKY;
            if (v >= 170 && v < 230) return COL_PATH;
            return COL_GRASS;
        end
        for (int c = 0; c < NUM_CARDS; c++) begin
            left = 105 + 110 * c;
            if (v >= 290 && v < 370 && h >= left && h < left + 100) begin
                ofs = h - left;
                cd  = int'(row.cds[c]);
                if (ofs < 2 || ofs >= 98 || v - 290 < 2 || v - 290 >= 78) return COL_BLACK;
                if (cd != 0 && ofs > cd * 3) return COL_GREY;
                return COL_WHITE;
            end
        end
        return COL_BOARD;
    endfunction

    task automatic check_pixel(input rgb_t actual, input rgb_t expected,
                               input coord_t h, input coord_t v);
        if (actual !== expected) begin
            error_count++;
            test_errors++;
            $display("FAILED at %0t ns: pixel at (%0d,%0d) is %03h, expected %03h",
                     $time, h, v, actual, expected);
        end
    endtask

    task automatic build_table();
        points[0] = '{'{10, 100}, '{300, 150}, '{500, 200}, '{639, 260},
                      '{640, 100}, '{700, 300}, '{100, 480}, '{0, 0}};
        points[1] = '{'{100, 50}, '{108, 50}, '{116, 58}, '{132, 50},
                      '{200, 50}, '{224, 50}, '{300, 166}, '{408, 180}};
        points[2] = '{'{100, 100}, '{108, 100}, '{120, 100}, '{300, 100},
                      '{310, 110}, '{104, 100}, '{130, 120}, '{110, 110}};
        points[3] = '{'{105, 290}, '{110, 300}, '{204, 300}, '{205, 300},
                      '{500, 280}, '{300, 400}, '{216, 292}, '{250, 330}};
        points[4] = '{'{120, 330}, '{121, 330}, '{245, 330}, '{246, 330},
                      '{418, 330}, '{419, 330}, '{438, 330}, '{439, 330}};
        for (int r = 0; r < NUM_ROWS; r++) begin
            rows[r] = '0;
        end
        rows[1].units[0] = make_unit(1'b1, KIND_KNIGHT, 100, 50);
        rows[1].units[1] = make_unit(1'b1, KIND_ARCHER, 200, 50);
        rows[1].units[2] = make_unit(1'b1, KIND_SLIME, 300, 150);
        rows[1].units[3] = make_unit(1'b1, KIND_BAT, 400, 180);
        rows[2].units[0] = make_unit(1'b1, KIND_SLIME, 100, 100);
        rows[2].units[1] = make_unit(1'b1, KIND_KNIGHT, 100, 100);
        rows[2].units[2] = make_unit(1'b0, KIND_ARCHER, 300, 100);
        rows[2].units[3] = make_unit(1'b1, KIND_BAT, 104, 100);
        rows[4].cds[0] = 5'd5;
        rows[4].cds[1] = 5'd10;
        rows[4].cds[2] = 5'd31;
        rows[4].cds[3] = 5'd1;
        for (int r = 0; r < NUM_FIXED; r++) begin
            for (int k = 0; k < NUM_POINTS; k++) begin
                rows[r].hs[k] = coord_t'(points[r][k][0]);
                rows[r].vs[k] = coord_t'(points[r][k][1]);
            end
        end
        // random rows crowd units and points into the top-left corner
        for (int r = NUM_FIXED; r < NUM_ROWS; r++) begin
            for (int i = 0; i < NUM_UNITS; i++) begin
                rows[r].units[i] = make_unit(($urandom % 4) != 0, unit_kind_e'(2'($urandom)),
                                             $urandom % 100, $urandom % 100);
            end
            for (int c = 0; c < NUM_CARDS; c++) begin
                rows[r].cds[c] = cooldown_t'($urandom);
            end
            for (int k = 0; k < NUM_POINTS; k++) begin
                rows[r].hs[k] = coord_t'($urandom % (k[0] ? 660 : 140));
                rows[r].vs[k] = coord_t'($urandom % (k[0] ? 500 : 140));
            end
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int k = 0; k < NUM_POINTS; k++) begin
                rows[r].expected[k] = model_pixel(rows[r], int'(rows[r].hs[k]),
                                                  int'(rows[r].vs[k]));
            end
        end
    endtask

    // back-to-back points, each pixel checked three edges after its point
    task automatic run_row(input int r);
        int j;
        for (int k = 0; k < NUM_POINTS + RENDER_LATENCY; k++) begin
            @(posedge clk_25MHz);
            if (k < NUM_POINTS) begin
                h_cnt <= rows[r].hs[k];
                v_cnt <= rows[r].vs[k];
                for (int i = 0; i < NUM_UNITS; i++) begin
                    units[i] <= rows[r].units[i];
                end
                for (int c = 0; c < NUM_CARDS; c++) begin
                    cooldowns[c] <= rows[r].cds[c];
                end
            end
            @(negedge clk_25MHz);
            if (k >= RENDER_LATENCY) begin
                j = k - RENDER_LATENCY;
                check_pixel(pixel, rows[r].expected[j], rows[r].hs[j], rows[r].vs[j]);
            end
        end
    endtask

    initial begin
        for (int c = 0; c < MAX_CYCLES; c++) begin
            @(posedge clk_25MHz);
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        h_cnt = '0;
        v_cnt = '0;
        for (int i = 0; i < NUM_UNITS; i++) begin
            units[i] = '0;
        end
        for (int c = 0; c < NUM_CARDS; c++) begin
            cooldowns[c] = '0;
        end
        void'($urandom(seed));
        build_table();
        repeat (8) @(posedge clk_25MHz);
        rst_n <= 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            test_errors = 0;
            run_row(r);
            if (test_errors != 0) tests_failed++;
            $display("test %0d %s: %0d mismatches", r, row_names[r], test_errors);
        end
        $display("%0d of %0d tests failed, %0d mismatches, %0d assertion failures",
                 tests_failed, NUM_ROWS, error_count,
                 u_play_render.u_play_render_properties.assert_failures);
        if (error_count == 0 && u_play_render.u_play_render_properties.assert_failures == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
